/* include/ahb_apb_consts.svh */
`ifndef AHB_APB_CONSTS_SVH
`define AHB_APB_CONSTS_SVH

// bus and address width
`define AHB_DATA_WIDTH 32

// slave windows behind the bridge
`define AHB_SLAVES 4

// config space covers word addresses 0..8
`define CFG_LAST_ADDR 8
`define CFG_WAIT_ADDR 0

// window bases out of reset
`define SLAVE_BASE_RESET_0 32'h8000_0000
`define SLAVE_BASE_RESET_1 32'h8400_0000
`define SLAVE_BASE_RESET_2 32'h8800_0000
`define SLAVE_BASE_RESET_3 32'h8C00_0000

// same span for every window
`define SLAVE_OFFSET_RESET 32'h0000_03FF

// ERROR response length in cycles
`define ERR_RESP_CYCLES 2

`endif

/* source/ahb_bus_pkg.sv */
package ahb_bus_pkg;

        typedef enum logic [1:0]
        {
                IDLE   = 2'b00,
                BUSY   = 2'b01,
                NONSEQ = 2'b10,
                SEQ    = 2'b11
        } htrans_t;

        // 0 = byte ... 7 = 1024 bits
        typedef logic [2:0] hsize_t;

        typedef enum logic [1:0]
        {
                OKAY  = 2'b00,
                ERROR = 2'b10
        } hresp_t;

        typedef enum logic [1:0]
        {
                RESP_IDLE = 2'b00,
                RESP_ERR1 = 2'b01,      // Hreadyout low
                RESP_ERR2 = 2'b10       // Hreadyout high
        } resp_state_t;

endpackage

/* source/apb_map_pkg.sv */
`include "ahb_apb_consts.svh"

package apb_map_pkg;

        typedef logic [`AHB_DATA_WIDTH-1:0] haddr_t;

        typedef logic [`AHB_DATA_WIDTH-1:0] hdata_t;

        // one bit per slave window
        typedef logic [`AHB_SLAVES-1:0] psel_t;

        // wait-time at 0, base/offset pairs at 1..8
        typedef logic [3:0] cfg_index_t;

endpackage

/* source/ahb_transfer_check.sv */
`include "ahb_apb_consts.svh"

module ahb_transfer_check (
        input  logic                    Hclk,
        input  logic                    Hresetn,
        input  ahb_bus_pkg::htrans_t    Htrans,
        input  ahb_bus_pkg::hsize_t     Hsize,
        input  apb_map_pkg::haddr_t     Haddr,
        input  logic                    Hwrite,
        input  logic                    Hreadyin,
        input  logic                    resp_busy,
        output logic                    err_detect,
        output logic                    cfg_wr_pend,
        output logic                    cfg_rd_pend,
        output apb_map_pkg::cfg_index_t cfg_index
);
        import ahb_bus_pkg::*;
        import apb_map_pkg::*;

        htrans_t htrans_prev;
        hsize_t  hsize_prev;
        logic    hwrite_prev;
        logic    seq_ok_prev;           // last beat accepted, SEQ may follow it
        haddr_t  align_mask;
        logic    addr_phase;
        logic    is_cfg;
        logic    misaligned;
        logic    seq_after_idle;
        logic    seq_mismatch;
        logic    oversize;
        logic    any_err;

        assign addr_phase = Hreadyin && (Htrans == NONSEQ || Htrans == SEQ);
        assign is_cfg     = (Haddr <= haddr_t'(`CFG_LAST_ADDR));
        assign align_mask = (haddr_t'(1) << Hsize) - haddr_t'(1);

        // config space is word indexed, so no alignment rule there
        assign misaligned     = !is_cfg && ((Haddr & align_mask) != '0);
        assign seq_after_idle = (Htrans == SEQ) && (htrans_prev == IDLE);
        assign seq_mismatch   = (Htrans == SEQ) && seq_ok_prev &&
                                ((Hsize != hsize_prev) || (Hwrite != hwrite_prev));
        assign oversize       = (32'd8 << Hsize) > `AHB_DATA_WIDTH;

        assign any_err = addr_phase && !resp_busy &&
                         (misaligned || seq_after_idle || seq_mismatch || oversize);

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        htrans_prev <= IDLE;
                        hsize_prev  <= '0;
                        hwrite_prev <= 1'b0;
                        seq_ok_prev <= 1'b0;
                        err_detect  <= 1'b0;
                end
                else
                begin
                        err_detect <= any_err;  // single pulse
                        if (Hreadyin)
                        begin
                                htrans_prev <= Htrans;
                                if (addr_phase)
                                begin
                                        hsize_prev  <= Hsize;
                                        hwrite_prev <= Hwrite;
                                        seq_ok_prev <= !any_err;
                                end
                                else if (Htrans == IDLE)
                                        seq_ok_prev <= 1'b0;
                        end
                end
        end

        // data phase bookkeeping for config accesses
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        cfg_wr_pend <= 1'b0;
                        cfg_rd_pend <= 1'b0;
                        cfg_index   <= '0;
                end
                else
                begin
                        cfg_wr_pend <= addr_phase && is_cfg && Hwrite;
                        cfg_rd_pend <= addr_phase && is_cfg && !Hwrite;
                        if (addr_phase && is_cfg)
                                cfg_index <= cfg_index_t'(Haddr);
                end
        end

endmodule

/* source/ahb_config_regs.sv */
`include "ahb_apb_consts.svh"

module ahb_config_regs (
        input  logic                    Hclk,
        input  logic                    Hresetn,
        input  ahb_bus_pkg::htrans_t    Htrans,
        input  logic                    Hreadyin,
        input  apb_map_pkg::haddr_t     Haddr,
        input  apb_map_pkg::hdata_t     Hwdata,
        input  ahb_bus_pkg::hresp_t     hresp,
        input  logic                    cfg_wr_pend,
        input  logic                    cfg_rd_pend,
        input  apb_map_pkg::cfg_index_t cfg_index,
        output apb_map_pkg::psel_t      Pselx_out,
        output apb_map_pkg::hdata_t     config_reg_data,
        output logic                    time_out
);
        import ahb_bus_pkg::*;
        import apb_map_pkg::*;

        localparam int NUM_REGS = `CFG_LAST_ADDR + 1;

        localparam hdata_t BASE_RESET [`AHB_SLAVES] = '{
                `SLAVE_BASE_RESET_0,
                `SLAVE_BASE_RESET_1,
                `SLAVE_BASE_RESET_2,
                `SLAVE_BASE_RESET_3
        };

        hdata_t cfg_regs [NUM_REGS];
        hdata_t wait_count;
        logic   [`AHB_DATA_WIDTH:0] win_end [`AHB_SLAVES];     // extra bit, no wrap
        logic   wr_en;

        // data phase of a config write, dropped on stall or ERROR
        assign wr_en = cfg_wr_pend && Hreadyin && (hresp == OKAY);

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        for (int i = 0; i < NUM_REGS; i++)
                        begin
                                if (i == `CFG_WAIT_ADDR)
                                        cfg_regs[i] <= '0;
                                else if (i % 2 == 1)
                                        cfg_regs[i] <= BASE_RESET[(i - 1) / 2];   // odd = base
                                else
                                        cfg_regs[i] <= `SLAVE_OFFSET_RESET;
                        end
                end
                else if (wr_en)
                        cfg_regs[cfg_index] <= Hwdata;
        end

        // read data held until the next config read
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                        config_reg_data <= '0;
                else if (cfg_rd_pend)
                        config_reg_data <= cfg_regs[cfg_index];
        end

        // window s: base at 2s+1, offset at 2s+2
        always_comb
        begin
                for (int s = 0; s < `AHB_SLAVES; s++)
                begin
                        win_end[s]   = {1'b0, cfg_regs[2*s+1]} + {1'b0, cfg_regs[2*s+2]};
                        Pselx_out[s] = (Haddr >= cfg_regs[2*s+1]) &&
                                       ({1'b0, Haddr} < win_end[s]);
                end
        end

        // consecutive BUSY beats against the wait-time register
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        wait_count <= '0;
                        time_out   <= 1'b0;
                end
                else if (Hreadyin && (Htrans == BUSY))
                begin
                        wait_count <= wait_count + 1'b1;
                        time_out   <= (wait_count == cfg_regs[`CFG_WAIT_ADDR]);
                end
                else
                begin
                        wait_count <= '0;
                        time_out   <= 1'b0;
                end
        end

endmodule

/* source/ahb_response.sv */
`include "ahb_apb_consts.svh"

module ahb_response (
        input  logic                    Hclk,
        input  logic                    Hresetn,
        input  ahb_bus_pkg::htrans_t    Htrans,
        input  apb_map_pkg::haddr_t     Haddr,
        input  logic                    Hwrite,
        input  logic                    Hreadyin,
        input  logic                    Hreadyout_in,
        input  logic                    err_detect,
        output ahb_bus_pkg::hresp_t     Hresp,
        output logic                    Hreadyout,
        output logic                    valid,
        output logic                    resp_busy
);
        import ahb_bus_pkg::*;
        import apb_map_pkg::*;

        resp_state_t state;
        resp_state_t next_state;
        logic        cfg_write;

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                        state <= RESP_IDLE;
                else
                        state <= next_state;
        end

        // two cycle ERROR, no new error accepted until it is done
        always_comb
        begin
                case (state)
                        RESP_IDLE: next_state = err_detect ? RESP_ERR1 : RESP_IDLE;
                        RESP_ERR1: next_state = RESP_ERR2;
                        default:   next_state = RESP_IDLE;
                endcase
        end

        assign Hresp     = (state == RESP_IDLE) ? OKAY : ERROR;
        assign resp_busy = (state != RESP_IDLE) || err_detect;     // pending error counts too

        assign cfg_write = Hwrite && (Haddr <= haddr_t'(`CFG_LAST_ADDR));

        always_comb
        begin
                if (Hresp == OKAY)
                        Hreadyout = cfg_write ? 1'b1 : Hreadyout_in;   // config writes never stall
                else
                        Hreadyout = (state == RESP_ERR2);
        end

        assign valid = Hreadyin && (Hresp == OKAY) &&
                       (Htrans == NONSEQ || Htrans == SEQ) && !cfg_write;

endmodule

/* source/ahb_apb_decoder.sv */
module ahb_apb_decoder (
        input  logic                    Hclk,
        input  logic                    Hresetn,
        input  ahb_bus_pkg::htrans_t    Htrans,
        input  ahb_bus_pkg::hsize_t     Hsize,
        input  logic                    Hreadyin,
        input  apb_map_pkg::hdata_t     Hwdata,
        input  apb_map_pkg::haddr_t     Haddr,
        input  logic                    Hwrite,
        input  logic                    Hreadyout_in,
        output ahb_bus_pkg::hresp_t     Hresp,
        output logic                    Hreadyout,
        output apb_map_pkg::psel_t      Pselx_out,
        output logic                    valid,
        output apb_map_pkg::hdata_t     config_reg_data,
        output logic                    time_out
);
        logic                    err_detect;
        logic                    cfg_wr_pend;
        logic                    cfg_rd_pend;
        apb_map_pkg::cfg_index_t cfg_index;
        logic                    resp_busy;

        ahb_transfer_check u_check (
                .Hclk        (Hclk),
                .Hresetn     (Hresetn),
                .Htrans      (Htrans),
                .Hsize       (Hsize),
                .Haddr       (Haddr),
                .Hwrite      (Hwrite),
                .Hreadyin    (Hreadyin),
                .resp_busy   (resp_busy),
                .err_detect  (err_detect),
                .cfg_wr_pend (cfg_wr_pend),
                .cfg_rd_pend (cfg_rd_pend),
                .cfg_index   (cfg_index)
        );

        ahb_config_regs u_regs (
                .Hclk            (Hclk),
                .Hresetn         (Hresetn),
                .Htrans          (Htrans),
                .Hreadyin        (Hreadyin),
                .Haddr           (Haddr),
                .Hwdata          (Hwdata),
                .hresp           (Hresp),
                .cfg_wr_pend     (cfg_wr_pend),
                .cfg_rd_pend     (cfg_rd_pend),
                .cfg_index       (cfg_index),
                .Pselx_out       (Pselx_out),
                .config_reg_data (config_reg_data),
                .time_out        (time_out)
        );

        ahb_response u_resp (
                .Hclk         (Hclk),
                .Hresetn      (Hresetn),
                .Htrans       (Htrans),
                .Haddr        (Haddr),
                .Hwrite       (Hwrite),
                .Hreadyin     (Hreadyin),
                .Hreadyout_in (Hreadyout_in),
                .err_detect   (err_detect),
                .Hresp        (Hresp),
                .Hreadyout    (Hreadyout),
                .valid        (valid),
                .resp_busy    (resp_busy)
        );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
        parameter int PERIOD = 40
) (
        output logic clk
);
        initial
        begin
                clk = 1'b0;
                forever
                        #(PERIOD / 2) clk = ~clk;
        end

endmodule

/* test/ahb_apb_checker.sv */
module ahb_apb_checker (
        input  logic                Hclk,
        input  logic                Hresetn,
        input  ahb_bus_pkg::hresp_t Hresp,
        input  logic                Hreadyout,
        input  apb_map_pkg::psel_t  Pselx_out,
        input  logic                valid,
        input  apb_map_pkg::hdata_t config_reg_data,
        input  logic                time_out,
        input  logic [5:0]          chk_mask,
        input  ahb_bus_pkg::hresp_t exp_hresp,
        input  logic                exp_hreadyout,
        input  apb_map_pkg::psel_t  exp_psel,
        input  logic                exp_valid,
        input  apb_map_pkg::hdata_t exp_cfg_data,
        input  logic                exp_time_out,
        input  int                  test_num,
        input  logic [8*20-1:0]     test_name,
        input  logic                finish_req,
        output logic                report_done,
        output int                  error_total
);
        int              cur_test = 0;
        logic [8*20-1:0] cur_name = '0;
        int              test_errs = 0;
        int              tests_run = 0;
        int              checks_run = 0;

        initial
        begin
                report_done = 1'b0;
                error_total = 0;
        end

        task automatic compare_value(input string sig, input logic [31:0] got,
                                     input logic [31:0] exp);
                checks_run++;
                if (got !== exp)
                begin
                        error_total++;
                        test_errs++;
                        $display("ERROR %0s: got %h expected %h in %0s", sig, got, exp, cur_name);
                end
        endtask

        task automatic close_test();
                if (cur_test != 0)
                begin
                        tests_run++;
                        if (test_errs == 0)
                                $display("PASS %0s", cur_name);
                        else
                                $display("FAIL %0s with %0d errors", cur_name, test_errs);
                end
        endtask

        // outputs are settled at the falling edge
        always @(negedge Hclk)
        begin
                if (test_num != cur_test)
                begin
                        close_test();
                        cur_test  = test_num;
                        cur_name  = test_name;
                        test_errs = 0;
                end
                if (Hresetn && !report_done)
                begin
                        if (chk_mask[0])
                                compare_value("Hresp", 32'(Hresp), 32'(exp_hresp));
                        if (chk_mask[1])
                                compare_value("Hreadyout", 32'(Hreadyout), 32'(exp_hreadyout));
                        if (chk_mask[2])
                                compare_value("Pselx_out", 32'(Pselx_out), 32'(exp_psel));
                        if (chk_mask[3])
                                compare_value("valid", 32'(valid), 32'(exp_valid));
                        if (chk_mask[4])
                                compare_value("config_reg_data", config_reg_data, exp_cfg_data);
                        if (chk_mask[5])
                                compare_value("time_out", 32'(time_out), 32'(exp_time_out));
                end
                if (finish_req && !report_done)
                begin
                        close_test();
                        $display("%0d tests, %0d checks, %0d errors", tests_run, checks_run,
                                 error_total);
                        report_done = 1'b1;
                end
        end

endmodule

/* test/ahb_apb_assertions.sv */
`include "ahb_apb_consts.svh"

module ahb_apb_assertions (
        input  logic                Hclk,
        input  logic                Hresetn,
        input  ahb_bus_pkg::hresp_t Hresp,
        input  logic                Hreadyout,
        input  logic                valid
);
        import ahb_bus_pkg::*;

        int fail_count = 0;     // assertion failures so far

        // two cycle ERROR, wait state first
        err_two_cycles: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Hresp == ERROR && $past(Hresp) == OKAY) |->
                !Hreadyout ##(`ERR_RESP_CYCLES - 1) (Hresp == ERROR && Hreadyout)
                ##1 (Hresp == OKAY))
        else
        begin
                fail_count++;
                $error("ERROR response does not last exactly two cycles");
        end

        no_valid_in_err: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Hresp == ERROR) |-> !valid)
        else
        begin
                fail_count++;
                $error("valid high during ERROR response");
        end

endmodule

/* test/tb_ahb_apb_decoder.sv */
module tb_ahb_apb_decoder;
        import ahb_bus_pkg::*;
        import apb_map_pkg::*;

        localparam int MAX_LINES = 500;
        localparam int WAIT_LIMIT = 20;

        logic Hclk;
        logic Hresetn;
        htrans_t Htrans;
        hsize_t Hsize;
        logic Hreadyin;
        hdata_t Hwdata;
        haddr_t Haddr;
        logic Hwrite;
        logic Hreadyout_in;
        hresp_t Hresp;
        logic Hreadyout;
        psel_t Pselx_out;
        logic valid;
        hdata_t config_reg_data;
        logic time_out;

        logic [5:0] chk_mask;
        hresp_t exp_hresp;
        logic exp_hreadyout;
        psel_t exp_psel;
        logic exp_valid;
        hdata_t exp_cfg_data;
        logic exp_time_out;
        int test_num;
        logic [8*20-1:0] test_name;
        logic finish_req;
        logic report_done;
        int error_total;

        logic [31:0] fld [14];
        logic [8*20-1:0] new_name;
        string line;
        integer fd;
        integer code;
        int lines;
        int next_num;
        int n;
        logic name_pending;
        logic run_abort;

        tb_clock_gen #(.PERIOD(40)) u_clk (.clk(Hclk));

        ahb_apb_decoder UUT (.*);

        ahb_apb_checker u_checker (.*);

        bind ahb_response ahb_apb_assertions u_resp_assert (
                .Hclk(Hclk), .Hresetn(Hresetn), .Hresp(Hresp),
                .Hreadyout(Hreadyout), .valid(valid)
        );

        // next test waits for a running ERROR response to end
        task automatic wait_resp_okay();
                int cnt;
                cnt = 0;
                @(negedge Hclk);
                while (Hresp != OKAY && cnt < WAIT_LIMIT)
                begin
                        @(negedge Hclk);
                        cnt++;
                end
                if (Hresp != OKAY)
                begin
                        $display("timeout waiting for Hresp to return to OKAY");
                        run_abort = 1'b1;
                end
        endtask

        initial
        begin
                int cycles;
                cycles = 0;
                while (cycles < 5000)
                begin
                        @(posedge Hclk);
                        cycles++;
                end
                $display("simulation watchdog expired");
                $display("Test failed");
                $finish;
        end

        initial
        begin
                Hresetn = 1'b0;
                Htrans = IDLE;
                Hsize = 3'd2;
                Hreadyin = 1'b1;
                Hwdata = '0;
                Haddr = '0;
                Hwrite = 1'b0;
                Hreadyout_in = 1'b1;
                chk_mask = '0;
                exp_hresp = OKAY;
                exp_hreadyout = 1'b0;
                exp_psel = '0;
                exp_valid = 1'b0;
                exp_cfg_data = '0;
                exp_time_out = 1'b0;
                test_num = 0;
                test_name = '0;
                finish_req = 1'b0;
                next_num = 0;
                name_pending = 1'b0;
                run_abort = 1'b0;
                lines = 0;
                repeat (2) @(posedge Hclk);
                Hresetn <= 1'b1;

                fd = $fopen("test/ahb_apb_cases.txt", "r");
                if (fd == 0)
                begin
                        $display("cannot open test/ahb_apb_cases.txt");
                        run_abort = 1'b1;
                end
                else
                begin
                        while (!$feof(fd) && lines < MAX_LINES && !run_abort)
                        begin
                                code = $fgets(line, fd);
                                if (code > 0 && line.len() > 0 && line[0] == "T")
                                begin
                                        code = $sscanf(line, "T %s", new_name);
                                        wait_resp_okay();
                                        next_num++;
                                        name_pending = 1'b1;
                                end
                                else if (code > 0 && line.len() > 0 && line[0] == "C")
                                begin
                                        code = $sscanf(line,
                                                "C %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                                fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                                                fld[12], fld[13]);
                                        if (code != 14)
                                        begin
                                                $display("malformed case line %0d", lines + 1);
                                                run_abort = 1'b1;
                                        end
                                        else
                                        begin
                                                @(posedge Hclk);
                                                Htrans <= htrans_t'(fld[0][1:0]);
                                                Hsize <= fld[1][2:0];
                                                Hreadyin <= fld[2][0];
                                                Hwrite <= fld[3][0];
                                                Hreadyout_in <= fld[4][0];
                                                Haddr <= fld[5];
                                                Hwdata <= fld[6];
                                                chk_mask <= fld[7][5:0];
                                                exp_hresp <= hresp_t'(fld[8][1:0]);
                                                exp_hreadyout <= fld[9][0];
                                                exp_psel <= fld[10][3:0];
                                                exp_valid <= fld[11][0];
                                                exp_cfg_data <= fld[12];
                                                exp_time_out <= fld[13][0];
                                                if (name_pending)
                                                begin
                                                        test_num <= next_num;
                                                        test_name <= new_name;
                                                        name_pending = 1'b0;
                                                end
                                        end
                                end
                                lines++;
                        end
                        $fclose(fd);
                end

                @(posedge Hclk);
                Htrans <= IDLE;
                Hwrite <= 1'b0;
                Haddr <= '0;
                chk_mask <= '0;
                finish_req <= 1'b1;
                n = 0;
                @(posedge Hclk);
                while (!report_done && n < WAIT_LIMIT)
                begin
                        @(posedge Hclk);
                        n++;
                end
                if (!report_done)
                        $display("checker did not report the summary");
                if (UUT.u_resp.u_resp_assert.fail_count != 0)
                        $display("%0d assertion failures",
                                 UUT.u_resp.u_resp_assert.fail_count);
                if (!run_abort && report_done && error_total == 0 &&
                    UUT.u_resp.u_resp_assert.fail_count == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

/* ahb_apb_decoder.f */
+incdir+include
source/ahb_bus_pkg.sv
source/apb_map_pkg.sv
source/ahb_transfer_check.sv
source/ahb_config_regs.sv
source/ahb_response.sv
source/ahb_apb_decoder.sv
test/tb_clock_gen.sv
test/ahb_apb_checker.sv
test/ahb_apb_assertions.sv
test/tb_ahb_apb_decoder.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= ahb_apb_decoder.f
RTL_TOP   ?= ahb_apb_decoder
TB_TOP    ?= tb_ahb_apb_decoder
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/ahb_apb_cases.txt */
# C htrans hsize hreadyin hwrite hreadyout_in haddr hwdata | mask hresp hreadyout psel valid cfgdata time_out
# mask bits: 1 hresp, 2 hreadyout, 4 psel, 8 valid, 10 cfgdata, 20 time_out; T name starts a test
T reset_values
C 2 2 1 0 1 00000001 00000000 11 0 0 0 0 00000000 0
C 2 2 1 0 1 00000002 00000000 01 0 0 0 0 00000000 0
C 2 2 1 0 1 00000003 00000000 10 0 0 0 0 80000000 0
C 2 2 1 0 1 00000004 00000000 10 0 0 0 0 000003ff 0
C 2 2 1 0 1 00000005 00000000 10 0 0 0 0 84000000 0
C 2 2 1 0 1 00000006 00000000 10 0 0 0 0 000003ff 0
C 2 2 1 0 1 00000007 00000000 10 0 0 0 0 88000000 0
C 2 2 1 0 1 00000008 00000000 10 0 0 0 0 000003ff 0
C 2 2 1 0 1 00000000 00000000 10 0 0 0 0 8c000000 0
C 0 2 1 0 1 00000000 00000000 10 0 0 0 0 000003ff 0
C 0 2 1 0 1 00000000 00000000 11 0 0 0 0 00000000 0
T write_readback
C 2 2 1 1 0 00000000 00000000 0b 0 1 0 0 00000000 0
C 2 2 1 1 0 00000004 00000007 0b 0 1 0 0 00000000 0
C 2 2 1 1 0 00000001 00000100 0b 0 1 0 0 00000000 0
C 0 2 1 0 1 00000000 90000000 00 0 0 0 0 00000000 0
C 2 2 1 0 1 00000000 00000000 00 0 0 0 0 00000000 0
C 2 2 1 0 1 00000004 00000000 00 0 0 0 0 00000000 0
C 2 2 1 0 1 00000001 00000000 10 0 0 0 0 00000007 0
C 0 2 1 0 1 00000000 00000000 10 0 0 0 0 00000100 0
C 0 2 1 0 1 00000000 00000000 10 0 0 0 0 90000000 0
T slave_select
C 0 2 1 0 1 88000000 00000000 04 0 0 4 0 00000000 0
C 0 2 1 0 1 880003fe 00000000 04 0 0 4 0 00000000 0
C 0 2 1 0 1 880003ff 00000000 04 0 0 0 0 00000000 0
C 0 2 1 0 1 90000000 00000000 04 0 0 1 0 00000000 0
C 0 2 1 0 1 840000ff 00000000 04 0 0 2 0 00000000 0
C 0 2 1 0 1 84000100 00000000 04 0 0 0 0 00000000 0
T ready_valid
C 2 2 1 0 0 88000000 00000000 0f 0 0 4 1 00000000 0
C 2 2 1 1 1 88000004 00000000 0f 0 1 4 1 00000000 0
T error_checks
C 2 2 1 0 1 88000002 00000000 01 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 0 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 03 0 1 0 0 00000000 0
C 3 2 1 0 1 88000000 00000000 01 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 0 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 03 0 1 0 0 00000000 0
C 2 2 1 0 1 88000000 00000000 01 0 0 0 0 00000000 0
C 3 1 1 0 1 88000004 00000000 01 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 0 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 03 0 1 0 0 00000000 0
C 2 3 1 0 1 88000000 00000000 01 0 0 0 0 00000000 0
C 2 2 1 1 1 00000000 00000000 0b 0 1 0 0 00000000 0
C 0 2 1 0 1 00000000 000000aa 0b 2 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 0b 2 1 0 0 00000000 0
C 2 2 1 0 1 00000000 00000000 03 0 1 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 00 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 10 0 0 0 0 00000007 0
T busy_timeout
C 2 2 1 1 1 00000000 00000000 00 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000003 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 1 2 1 0 1 88000000 00000000 20 0 0 0 0 00000000 0
C 0 2 1 0 1 00000000 00000000 20 0 0 0 0 00000000 1
C 0 2 1 0 1 00000000 00000000 20 0 0 0 0 00000000 0
